//--- hdl/video_timing_pkg.sv
//******************************
// Screen geometry constants
// Beam position and sync types
//******************************

package video_timing_pkg;

    // Horizontal geometry in pixels
    localparam int H_TOTAL   = 384;
    localparam int H_VISIBLE = 256;
    localparam int HS_START  = 300;
    localparam int HS_END    = 331;
    // 8-pixel tile windows per line
    localparam int H_TILES   = H_TOTAL / 8;

    // Vertical geometry in lines
    localparam int V_TOTAL   = 264;
    localparam int V_START   = 16;
    localparam int V_END     = 239;
    localparam int VS_START  = 250;
    localparam int VS_END    = 252;

    // Interrupt active while vdump[5:3] matches
    localparam logic [2:0] IRQ_PHASE = 3'd6;

    typedef logic [8:0] hpos_t;
    typedef logic [8:0] vpos_t;

    typedef struct packed {
        hpos_t hdump;
        vpos_t vdump;
    } screen_pos_t;

    // Blanking active low, syncs active low
    typedef struct packed {
        logic lhbl;
        logic lvbl;
        logic hs;
        logic vs;
    } video_sync_t;

    // Inactive state seen after reset
    localparam video_sync_t SYNC_RESET = '{lhbl: 1'b0, lvbl: 1'b0, hs: 1'b1, vs: 1'b1};

endpackage

//--- hdl/video_bus_pkg.sv
//******************************
// CPU bus and ROM request types
// Pixel and colour types
//******************************

package video_bus_pkg;

    // Graphics ROM word address width
    localparam int ROM_AW = 17;

    // CPU access, qualified by cen and a chip select
    typedef struct packed {
        logic        rnw;
        logic        cen;
        logic [13:0] addr;
        logic [7:0]  wdata;
    } cpu_bus_t;

    // Level request, held until the ok strobe
    typedef struct packed {
        logic [ROM_AW-1:0] addr;
        logic              cs;
    } rom_req_t;

    // Palette bank from attribute, pixel nibble from ROM
    typedef struct packed {
        logic [2:0] bank;
        logic [3:0] idx;
    } gfx_pxl_t;

    typedef struct packed {
        logic [4:0] red;
        logic [4:0] green;
        logic [4:0] blue;
    } rgb_t;

endpackage

//--- hdl/video_timer.sv
//******************************
// Video timing generator
// Pixel clock enables from clk
// Beam counters, blanking, sync
// CPU interrupt level
//******************************

`timescale 1ns/1ps

module video_timer (
    input  logic                          clk,
    input  logic                          rst_n,
    output logic                          pxl2_cen,
    output logic                          pxl_cen,
    output video_timing_pkg::screen_pos_t pos,
    output video_timing_pkg::video_sync_t sync,
    output logic                          cpu_irqn
);
    import video_timing_pkg::*;

    logic [2:0] cen_cnt;
    hpos_t      h_nxt;
    vpos_t      v_nxt;

    // Divide by 4 and by 8
    // Both enables land on cen_cnt == 7 so they coincide
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cen_cnt  <= 3'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cen_cnt  <= cen_cnt + 3'd1;
            pxl2_cen <= cen_cnt[1:0] == 2'd2;
            pxl_cen  <= cen_cnt == 3'd6;
        end
    end

    // Next beam position
    always_comb begin
        h_nxt = pos.hdump + 9'd1;
        v_nxt = pos.vdump;
        if (pos.hdump == H_TOTAL - 1) begin
            h_nxt = '0;
            // Line advances at the horizontal wrap
            if (pos.vdump == V_TOTAL - 1)
                v_nxt = '0;
            else
                v_nxt = pos.vdump + 9'd1;
        end
    end

    // Flags decoded from the next position
    // so they line up with the counters
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pos      <= '0;
            sync     <= SYNC_RESET;
            cpu_irqn <= 1'b1;
        end else if (pxl_cen) begin
            pos.hdump <= h_nxt;
            pos.vdump <= v_nxt;
            sync.lhbl <= h_nxt < H_VISIBLE;
            sync.lvbl <= v_nxt >= V_START && v_nxt <= V_END;
            sync.hs   <= !(h_nxt >= HS_START && h_nxt <= HS_END);
            sync.vs   <= !(v_nxt >= VS_START && v_nxt <= VS_END);
            // Four 8-line low periods per frame
            cpu_irqn  <= v_nxt[5:3] != IRQ_PHASE;
        end
    end

endmodule

//--- hdl/tile_gfx.sv
//******************************
// 8x8 tile layer
// Code and attribute RAM
// ROM row fetch one tile ahead
// Pixel shifter
//******************************

`timescale 1ns/1ps

module tile_gfx (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  video_timing_pkg::screen_pos_t pos,
    input  video_timing_pkg::video_sync_t sync,
    input  video_bus_pkg::cpu_bus_t       cpu,
    input  logic                          cs,
    input  logic [15:0]                   rom_data,
    input  logic                          rom_ok,
    input  logic                          gfx_en,
    output logic [7:0]                    rdata,
    output video_bus_pkg::rom_req_t       rom_req,
    output video_bus_pkg::gfx_pxl_t       pxl
);
    import video_timing_pkg::*;
    import video_bus_pkg::*;

    typedef enum logic [1:0] {ST_IDLE, ST_REQ0, ST_REQ1, ST_DRAIN} fetch_st_t;

    logic [7:0]        code_ram [0:1023];
    logic [7:0]        attr_ram [0:1023];
    logic              cpu_wr;
    logic              cpu_rd;
    logic              bound;
    logic              rd_stb;
    logic              last_win;
    logic              fetch_en;
    logic              fetch_pend;
    vpos_t             fetch_v;
    logic [9:0]        tile_idx;
    logic [7:0]        code_q;
    logic [7:0]        attr_q;
    logic [2:0]        line_q;
    fetch_st_t         st;
    logic              rom_cs;
    logic [ROM_AW-1:0] rom_addr;
    logic [31:0]       row_buf;
    logic [31:0]       shift;
    logic [2:0]        bank_cur;

    assign cpu_wr  = cpu.cen && cs && !cpu.rnw;
    assign cpu_rd  = cpu.cen && cs && cpu.rnw;
    // Last pixel of a tile column
    assign bound   = pxl_cen && pos.hdump[2:0] == 3'd7;
    assign rom_req = '{addr: rom_addr, cs: rom_cs};

    // Tile to fetch in the current window
    always_comb begin
        // Window before the line wrap fetches column 0 of the next line
        last_win = pos.hdump[8:3] == 6'(H_TILES - 1);
        fetch_v  = last_win ? pos.vdump + 9'd1 : pos.vdump;
        tile_idx = {fetch_v[7:3], last_win ? 5'd0 : pos.hdump[7:3] + 5'd1};
        // Skip windows that feed no visible pixel
        fetch_en = (sync.lvbl || pos.vdump == 9'(V_START - 1)) &&
                   (last_win || (sync.lhbl && pos.hdump[7:3] != 5'd31));
    end

    // CPU port and beam read, codes below 0x400
    always_ff @(posedge clk) begin
        if (cpu_wr && !cpu.addr[10])
            code_ram[cpu.addr[9:0]] <= cpu.wdata;
        if (cpu_wr && cpu.addr[10])
            attr_ram[cpu.addr[9:0]] <= cpu.wdata;
        if (cpu_rd)
            rdata <= cpu.addr[10] ? attr_ram[cpu.addr[9:0]] : code_ram[cpu.addr[9:0]];
        if (rd_stb) begin
            code_q <= code_ram[tile_idx];
            attr_q <= attr_ram[tile_idx];
            line_q <= fetch_v[2:0];
        end
    end

    // Fetch sequencer, two ROM words per tile
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_stb     <= 1'b0;
            fetch_pend <= 1'b0;
            st         <= ST_IDLE;
            rom_cs     <= 1'b0;
            rom_addr   <= '0;
            row_buf    <= '0;
        end else begin
            rd_stb <= bound;
            if (bound) begin
                // Shifter takes row_buf now, unfetched words stay zero
                row_buf <= '0;
                if (rom_cs && !rom_ok)
                    st <= ST_DRAIN;
                else
                    st <= ST_IDLE;
                if (rom_ok)
                    rom_cs <= 1'b0;
            end else begin
                case (st)
                    ST_IDLE: begin
                        if (fetch_pend) begin
                            fetch_pend <= 1'b0;
                            st         <= ST_REQ0;
                        end
                    end
                    ST_REQ0: begin
                        if (!rom_cs) begin
                            rom_cs   <= 1'b1;
                            rom_addr <= {attr_q[7:3], code_q, line_q, 1'b0};
                        end else if (rom_ok) begin
                            rom_cs         <= 1'b0;
                            row_buf[31:16] <= rom_data;
                            st             <= ST_REQ1;
                        end
                    end
                    ST_REQ1: begin
                        // cs was dropped for this cycle by the previous ok
                        if (!rom_cs) begin
                            rom_cs   <= 1'b1;
                            rom_addr <= {attr_q[7:3], code_q, line_q, 1'b1};
                        end else if (rom_ok) begin
                            rom_cs        <= 1'b0;
                            row_buf[15:0] <= rom_data;
                            st            <= ST_IDLE;
                        end
                    end
                    default: begin
                        // Late word from the previous tile, thrown away
                        if (rom_ok) begin
                            rom_cs <= 1'b0;
                            st     <= ST_IDLE;
                        end
                    end
                endcase
            end
            if (rd_stb)
                fetch_pend <= fetch_en;
        end
    end

    // Pixel 0 sits in the top nibble
    always_ff @(posedge clk) begin
        if (pxl_cen) begin
            pxl.bank <= bank_cur;
            pxl.idx  <= gfx_en ? shift[31:28] : 4'd0;
            if (pos.hdump[2:0] == 3'd7) begin
                shift    <= row_buf;
                bank_cur <= attr_q[2:0];
            end else begin
                shift <= {shift[27:0], 4'd0};
            end
        end
    end

endmodule

//--- hdl/pal_colmix.sv
//******************************
// Palette colour mixer
// 256-byte palette RAM
// Colour lookup per pixel
// Blanking delay and black out
//******************************

`timescale 1ns/1ps

module pal_colmix (
    input  logic                          clk,
    input  logic                          rst_n,
    input  logic                          pxl_cen,
    input  video_timing_pkg::video_sync_t sync,
    input  video_bus_pkg::cpu_bus_t       cpu,
    input  logic                          cs,
    input  video_bus_pkg::gfx_pxl_t       pxl,
    output logic [7:0]                    rdata,
    output video_timing_pkg::video_sync_t blank_dly,
    output video_bus_pkg::rgb_t           rgb
);
    import video_timing_pkg::*;
    import video_bus_pkg::*;

    // Even bytes hold the low half, odd bytes the high half
    logic [7:0]  pal_lo [0:127];
    logic [7:0]  pal_hi [0:127];
    logic        cpu_wr;
    logic        cpu_rd;
    logic [6:0]  col_idx;
    logic [14:0] colour;
    video_sync_t blank_mid;

    assign cpu_wr  = cpu.cen && cs && !cpu.rnw;
    assign cpu_rd  = cpu.cen && cs && cpu.rnw;
    assign col_idx = {pxl.bank, pxl.idx};

    // CPU side
    always_ff @(posedge clk) begin
        if (cpu_wr && !cpu.addr[0])
            pal_lo[cpu.addr[7:1]] <= cpu.wdata;
        if (cpu_wr && cpu.addr[0])
            pal_hi[cpu.addr[7:1]] <= cpu.wdata;
        if (cpu_rd)
            rdata <= cpu.addr[0] ? pal_hi[cpu.addr[7:1]] : pal_lo[cpu.addr[7:1]];
    end

    // Both bytes of the colour at once
    // Top bit of the high byte is unused
    assign colour = {pal_hi[col_idx][6:0], pal_lo[col_idx]};

    // Two-pixel pipeline for blanking
    // First stage matches the pixel held in pxl
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blank_mid <= SYNC_RESET;
            blank_dly <= SYNC_RESET;
            rgb       <= '0;
        end else if (pxl_cen) begin
            blank_mid <= sync;
            blank_dly <= blank_mid;
            // Black outside the active area
            if (blank_mid.lhbl && blank_mid.lvbl) begin
                rgb.red   <= colour[4:0];
                rgb.green <= colour[9:5];
                rgb.blue  <= colour[14:10];
            end else begin
                rgb <= '0;
            end
        end
    end

endmodule

//--- hdl/labrun_video.sv
//******************************
// Video section top level
// Timer, tile layer, colour mixer
//******************************

`timescale 1ns/1ps

module labrun_video (
    input  logic                             clk,
    input  logic                             rst_n,
    output logic                             pxl2_cen,
    output logic                             pxl_cen,
    output logic                             LHBL,
    output logic                             LVBL,
    output logic                             LHBL_dly,
    output logic                             LVBL_dly,
    output logic                             HS,
    output logic                             VS,
    // CPU
    input  logic                             gfx_cs,
    input  logic                             pal_cs,
    input  logic                             cpu_rnw,
    input  logic                             cpu_cen,
    input  logic [13:0]                      cpu_addr,
    input  logic [7:0]                       cpu_dout,
    output logic [7:0]                       gfx_dout,
    output logic [7:0]                       pal_dout,
    output logic                             cpu_irqn,
    // Graphics ROM
    output logic [video_bus_pkg::ROM_AW-1:0] gfx_addr,
    input  logic [15:0]                      gfx_data,
    input  logic                             gfx_ok,
    output logic                             gfx_romcs,
    // Colours
    output logic [4:0]                       red,
    output logic [4:0]                       green,
    output logic [4:0]                       blue,
    input  logic                             gfx_en
);
    import video_timing_pkg::*;
    import video_bus_pkg::*;

    cpu_bus_t    cpu;
    screen_pos_t pos;
    video_sync_t sync;
    video_sync_t blank_dly;
    rom_req_t    rom_req;
    gfx_pxl_t    gfx_pxl;
    rgb_t        rgb;

    // One bus for both chip selects
    assign cpu = '{rnw: cpu_rnw, cen: cpu_cen, addr: cpu_addr, wdata: cpu_dout};

    assign LHBL      = sync.lhbl;
    assign LVBL      = sync.lvbl;
    assign HS        = sync.hs;
    assign VS        = sync.vs;
    assign LHBL_dly  = blank_dly.lhbl;
    assign LVBL_dly  = blank_dly.lvbl;
    assign gfx_addr  = rom_req.addr;
    assign gfx_romcs = rom_req.cs;
    assign red       = rgb.red;
    assign green     = rgb.green;
    assign blue      = rgb.blue;

    video_timer u_timer (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl2_cen ( pxl2_cen ),
        .pxl_cen  ( pxl_cen  ),
        .pos      ( pos      ),
        .sync     ( sync     ),
        .cpu_irqn ( cpu_irqn )
    );

    tile_gfx u_gfx (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .pxl_cen  ( pxl_cen  ),
        .pos      ( pos      ),
        .sync     ( sync     ),
        .cpu      ( cpu      ),
        .cs       ( gfx_cs   ),
        .rom_data ( gfx_data ),
        .rom_ok   ( gfx_ok   ),
        .gfx_en   ( gfx_en   ),
        .rdata    ( gfx_dout ),
        .rom_req  ( rom_req  ),
        .pxl      ( gfx_pxl  )
    );

    pal_colmix u_colmix (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .pxl_cen   ( pxl_cen   ),
        .sync      ( sync      ),
        .cpu       ( cpu       ),
        .cs        ( pal_cs    ),
        .pxl       ( gfx_pxl   ),
        .rdata     ( pal_dout  ),
        .blank_dly ( blank_dly ),
        .rgb       ( rgb       )
    );

endmodule

//--- bench/tb_labrun_video.sv
//******************************
// Testbench for the video top
// Clock, reset, CPU writes/reads
// ROM model, pixel model, checks
//******************************

`timescale 1ns/1ps

module tb_labrun_video;
    import video_timing_pkg::*;
    import video_bus_pkg::*;

    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL * 8;
    // Three frames plus 32 lines of slack
    localparam longint TIMEOUT_NS = 64'(3 * FRAME_CYCLES + 32 * H_TOTAL * 8) * 100;
    localparam int ACTIVE_LINES = V_END - V_START + 1;

    logic              clk = 1'b0;
    logic              rst_n;
    logic              gfx_cs, pal_cs, cpu_rnw, cpu_cen, gfx_en;
    logic [13:0]       cpu_addr;
    logic [7:0]        cpu_dout;
    logic [15:0]       gfx_data;
    logic              gfx_ok;
    logic              pxl2_cen, pxl_cen, LHBL, LVBL, LHBL_dly, LVBL_dly, HS, VS;
    logic [7:0]        gfx_dout, pal_dout;
    logic              cpu_irqn, gfx_romcs;
    logic [ROM_AW-1:0] gfx_addr;
    logic [4:0]        red, green, blue;

    // Copies of what the CPU wrote
    logic [7:0] tile_mem [0:2047];
    logic [7:0] pal_mem [0:255];

    int   rom_wait = 0;
    int   frame_no = 0;
    int   px_x = 0;
    int   line_y = 0;
    int   act_lines = 0;
    int   irq_falls = 0;
    int   irq_low = 0;
    int   pix_checks = 0;
    logic lhbl_q = 1'b0;
    logic lvbl_q = 1'b0;
    logic irqn_q = 1'b1;
    rgb_t act_rgb;

    // Beam position model, counted from reset
    int          h_ref = 0;
    int          v_ref = 0;
    bit          beam_on = 1'b0;
    video_sync_t exp_sync;
    video_sync_t act_sync;
    video_sync_t sync_q1 = 4'b0011;
    video_sync_t sync_q2 = 4'b0011;

    // Enable spacing in clocks
    int clk_no = 0;
    int last1_clk = -1;
    int last2_clk = -1;

    // ROM request history
    logic              ok_seen = 1'b0;
    logic              cs_seen = 1'b0;
    logic [ROM_AW-1:0] addr_seen;

    labrun_video i_labrun_video (
        .clk(clk), .rst_n(rst_n), .pxl2_cen(pxl2_cen), .pxl_cen(pxl_cen),
        .LHBL(LHBL), .LVBL(LVBL), .LHBL_dly(LHBL_dly), .LVBL_dly(LVBL_dly),
        .HS(HS), .VS(VS), .gfx_cs(gfx_cs), .pal_cs(pal_cs), .cpu_rnw(cpu_rnw),
        .cpu_cen(cpu_cen), .cpu_addr(cpu_addr), .cpu_dout(cpu_dout),
        .gfx_dout(gfx_dout), .pal_dout(pal_dout), .cpu_irqn(cpu_irqn),
        .gfx_addr(gfx_addr), .gfx_data(gfx_data), .gfx_ok(gfx_ok),
        .gfx_romcs(gfx_romcs), .red(red), .green(green), .blue(blue), .gfx_en(gfx_en)
    );

    always #50 clk = ~clk;

    task automatic abort_run();
        $display("** FAIL **");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic check_rgb(input rgb_t exp, input rgb_t act, input string what);
        if (exp !== act) begin
            $display("Fail %0t: %s expected %h got %h", $time, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_sync(input video_sync_t exp, input video_sync_t act,
                              input string what);
        if (exp !== act) begin
            $display("Fail %0t: %s expected %b got %b", $time, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_byte(input logic [7:0] exp, input logic [7:0] act, input string what);
        if (exp !== act) begin
            $display("Fail %0t: %s expected %h got %h", $time, what, exp, act);
            abort_run();
        end
    endtask

    task automatic check_count(input int exp, input int act, input string what);
        if (exp != act) begin
            $display("Fail %0t: %s expected %0d got %0d", $time, what, exp, act);
            abort_run();
        end
    endtask

    // Graphics ROM content, hash of the word address
    function automatic logic [15:0] rom_word(input logic [ROM_AW-1:0] a);
        logic [31:0] p;
        p = 32'(a) * 32'h9E37;
        return p[15:0] ^ a[15:0];
    endfunction

    // Expected colour of screen pixel (x, y)
    function automatic rgb_t pixel_rgb(input int x, input int y, input bit layer_on);
        logic [8:0]        v;
        logic [8:0]        xx;
        int                ent;
        logic [7:0]        code;
        logic [7:0]        attr;
        logic [15:0]       word;
        logic [3:0]        nib;
        logic [6:0]        n;
        logic [14:0]       colour;
        rgb_t              res;
        v    = 9'(y + V_START);
        xx   = 9'(x);
        ent  = int'(v[7:3]) * 32 + int'(xx[7:3]);
        code = tile_mem[ent];
        attr = tile_mem[1024 + ent];
        word = rom_word({attr[7:3], code, v[2:0], xx[2]});
        // Pixel 0 in the top nibble of the word
        nib  = layer_on ? 4'(word >> (12 - 4 * int'(xx[1:0]))) : 4'd0;
        n    = {attr[2:0], nib};
        colour = {pal_mem[{n, 1'b1}][6:0], pal_mem[{n, 1'b0}]};
        res.red   = colour[4:0];
        res.green = colour[9:5];
        res.blue  = colour[14:10];
        return res;
    endfunction

    task automatic cpu_write(input bit to_pal, input logic [13:0] a, input logic [7:0] d);
        @(posedge clk);
        gfx_cs   <= !to_pal;
        pal_cs   <= to_pal;
        cpu_rnw  <= 1'b0;
        cpu_cen  <= 1'b1;
        cpu_addr <= a;
        cpu_dout <= d;
    endtask

    task automatic cpu_release();
        @(posedge clk);
        gfx_cs  <= 1'b0;
        pal_cs  <= 1'b0;
        cpu_rnw <= 1'b1;
        cpu_cen <= 1'b0;
    endtask

    // Data shows one edge after the access cycle
    task automatic cpu_read(input bit from_pal, input logic [13:0] a, output logic [7:0] q);
        @(posedge clk);
        gfx_cs   <= !from_pal;
        pal_cs   <= from_pal;
        cpu_rnw  <= 1'b1;
        cpu_cen  <= 1'b1;
        cpu_addr <= a;
        cpu_release();
        @(negedge clk);
        q = from_pal ? pal_dout : gfx_dout;
    endtask

    // Random upper address bits, ignored by the DUT
    task automatic load_memories();
        logic [7:0] d;
        for (int i = 0; i < 2048; i++) begin
            d = 8'($urandom);
            tile_mem[i] = d;
            cpu_write(1'b0, {3'($urandom), 11'(i)}, d);
        end
        for (int i = 0; i < 256; i++) begin
            d = 8'($urandom);
            pal_mem[i] = d;
            cpu_write(1'b1, {6'($urandom), 8'(i)}, d);
        end
        cpu_release();
    endtask

    task automatic read_back();
        logic [13:0] a;
        logic [7:0]  q;
        for (int i = 0; i < 48; i++) begin
            a = 14'($urandom);
            cpu_read(1'b0, a, q);
            check_byte(tile_mem[a[10:0]], q, "tile RAM readback");
        end
        for (int i = 0; i < 24; i++) begin
            a = 14'($urandom);
            cpu_read(1'b1, a, q);
            check_byte(pal_mem[a[7:0]], q, "palette readback");
        end
    endtask

    // ROM answers each request after 1 to 3 cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            gfx_ok   <= 1'b0;
            rom_wait <= 0;
            ok_seen  <= 1'b0;
            cs_seen  <= 1'b0;
        end else begin
            // Request drops after each ok and holds its address
            if (ok_seen && gfx_romcs) begin
                $display("Error: gfx_romcs stayed high after gfx_ok at %0t", $time);
                abort_run();
            end
            if (cs_seen && gfx_romcs && gfx_addr !== addr_seen) begin
                $display("Error: gfx_addr changed during a ROM request at %0t", $time);
                abort_run();
            end
            ok_seen   <= gfx_ok;
            cs_seen   <= gfx_romcs;
            addr_seen <= gfx_addr;
            gfx_ok    <= 1'b0;
            if (rom_wait == 0) begin
                if (gfx_romcs && !gfx_ok)
                    rom_wait <= $urandom_range(3, 1);
            end else if (rom_wait == 1) begin
                gfx_ok   <= 1'b1;
                gfx_data <= rom_word(gfx_addr);
                rom_wait <= 0;
            end else begin
                rom_wait <= rom_wait - 1;
            end
        end
    end

    // Enable spacing, every clock after reset
    always @(negedge clk) begin
        if (rst_n) begin
            clk_no = clk_no + 1;
            if (pxl_cen && !pxl2_cen) begin
                $display("Error: pxl_cen pulsed without pxl2_cen at %0t", $time);
                abort_run();
            end
            if (pxl2_cen) begin
                if (last2_clk >= 0)
                    check_count(4, clk_no - last2_clk, "clocks between pxl2_cen pulses");
                last2_clk = clk_no;
            end
            if (pxl_cen) begin
                if (last1_clk >= 0)
                    check_count(8, clk_no - last1_clk, "clocks between pxl_cen pulses");
                last1_clk = clk_no;
            end
        end
    end

    // Pixel monitor, sampled mid-cycle of each pxl_cen
    always @(negedge clk) begin
        if (rst_n && pxl_cen) begin
            // Blanking keeps its reset value on the first pixel
            exp_sync.lhbl = beam_on && h_ref < H_VISIBLE;
            exp_sync.lvbl = v_ref >= V_START && v_ref <= V_END;
            exp_sync.hs   = !(h_ref >= HS_START && h_ref <= HS_END);
            exp_sync.vs   = !(v_ref >= VS_START && v_ref <= VS_END);
            act_sync      = {LHBL, LVBL, HS, VS};
            check_sync(exp_sync, act_sync, "blanking and sync");
            check_count(int'({sync_q2.lhbl, sync_q2.lvbl}), int'({LHBL_dly, LVBL_dly}),
                        "delayed blanking");
            check_count(int'((v_ref / 8) % 8 != 6), int'(cpu_irqn), "cpu_irqn level");
            act_rgb.red   = red;
            act_rgb.green = green;
            act_rgb.blue  = blue;
            if (LVBL_dly && !lvbl_q) begin
                frame_no = frame_no + 1;
                if (frame_no >= 2)
                    check_count(4, irq_falls, "interrupts per frame");
                irq_falls = 0;
                act_lines = 0;
            end
            if (!LVBL_dly && lvbl_q)
                check_count(ACTIVE_LINES, act_lines, "active lines per frame");
            if (LHBL_dly && !lhbl_q) begin
                px_x = 0;
                if (LVBL_dly) begin
                    line_y    = act_lines;
                    act_lines = act_lines + 1;
                end
            end
            if (!LHBL_dly && lhbl_q && LVBL_dly)
                check_count(H_VISIBLE, px_x, "active pixels per line");
            if (LHBL_dly && LVBL_dly) begin
                // Layer on in frame 2, off in frame 3
                if (frame_no == 2 || frame_no == 3) begin
                    check_rgb(pixel_rgb(px_x, line_y, frame_no == 2), act_rgb, "pixel colour");
                    pix_checks = pix_checks + 1;
                end
                px_x = px_x + 1;
            end else begin
                check_rgb(15'd0, act_rgb, "rgb in blanking");
            end
            // Interrupt edges and low length
            if (!cpu_irqn) begin
                irq_low = irq_low + 1;
                if (irqn_q)
                    irq_falls = irq_falls + 1;
            end else if (!irqn_q) begin
                check_count(8 * H_TOTAL, irq_low, "interrupt low length");
                irq_low = 0;
            end
            lhbl_q = LHBL_dly;
            lvbl_q = LVBL_dly;
            irqn_q = cpu_irqn;
            // Advance the beam model with the pixel enable
            sync_q2 = sync_q1;
            sync_q1 = exp_sync;
            beam_on = 1'b1;
            if (h_ref == H_TOTAL - 1) begin
                h_ref = 0;
                v_ref = (v_ref == V_TOTAL - 1) ? 0 : v_ref + 1;
            end else begin
                h_ref = h_ref + 1;
            end
        end
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the video frames did not finish in time");
        abort_run();
    end

    initial begin
        void'($urandom(32'h3505));
        rst_n    <= 1'b0;
        gfx_cs   <= 1'b0;
        pal_cs   <= 1'b0;
        cpu_rnw  <= 1'b1;
        cpu_cen  <= 1'b0;
        cpu_addr <= '0;
        cpu_dout <= '0;
        gfx_data <= '0;
        gfx_ok   <= 1'b0;
        gfx_en   <= 1'b1;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        // Both fills land in the first vertical blank
        load_memories();
        read_back();
        wait (frame_no == 2);
        @(negedge LVBL_dly);
        @(posedge clk);
        gfx_en <= 1'b0;
        wait (frame_no == 4);
        @(posedge clk);
        if (pix_checks == 2 * H_VISIBLE * ACTIVE_LINES) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("Only %0d pixels were compared with the model", pix_checks);
            abort_run();
        end
    end

endmodule

//--- project.f
hdl/video_timing_pkg.sv
hdl/video_bus_pkg.sv
hdl/video_timer.sv
hdl/tile_gfx.sv
hdl/pal_colmix.sv
hdl/labrun_video.sv
bench/tb_labrun_video.sv
